// File: conv_ctrl_consts.svh
`ifndef CONV_CTRL_CONSTS_SVH
`define CONV_CTRL_CONSTS_SVH

// Width of one loop index and of one loop range.
`define CTRL_IDX_W 8

// Width of a base address.
`define CTRL_ADDR_W 32

// Width of a programmed stride.
`define CTRL_STRIDE_W 16

// Nested loops k_out, i, j, k_in.
`define CTRL_NB_LOOPS 4

// Encoding width of the sequencer state.
`define CTRL_STATE_W 4

`endif

// File: conv_ctrl_pkg.sv
`include "conv_ctrl_consts.svh"

package conv_ctrl_pkg;

  typedef enum logic [0:0] {
    FILTER_NORMAL    = 1'b0,
    FILTER_DEPTHWISE = 1'b1
  } filter_mode_e;

  typedef enum logic [`CTRL_STATE_W-1:0] {
    IDLE,
    LOAD,
    WEIGHTOFFS,
    MATRIXVEC,
    UPDATEIDX,
    NORMQUANT,
    NORMQUANT_BIAS,
    STREAMOUT,
    DONE
  } ctrl_state_e;

  // Static job configuration.
  typedef struct packed {
    filter_mode_e              filter_mode;
    logic [`CTRL_IDX_W-1:0]    nb_ko;
    logic [`CTRL_IDX_W-1:0]    nb_ho;
    logic [`CTRL_IDX_W-1:0]    nb_wo;
    logic [`CTRL_IDX_W-1:0]    nb_ki;
    logic                      quant_en;
    logic                      bias_en;
    logic [`CTRL_STRIDE_W-1:0] w_stride_ko;
    logic [`CTRL_STRIDE_W-1:0] w_stride_ki;
    logic [`CTRL_STRIDE_W-1:0] x_stride_i;
    logic [`CTRL_STRIDE_W-1:0] x_stride_j;
    logic [`CTRL_STRIDE_W-1:0] x_stride_k;
    logic [`CTRL_STRIDE_W-1:0] y_stride_i;
    logic [`CTRL_STRIDE_W-1:0] y_stride_j;
    logic [`CTRL_STRIDE_W-1:0] y_stride_k;
  } ctrl_config_t;

  // Single-cycle pulses from the engine.
  typedef struct packed {
    logic load_done;
    logic accum_done;
    logic nq_done;
    logic nq_bias_done;
    logic streamout_done;
  } engine_evt_t;

  typedef struct packed {
    logic [`CTRL_IDX_W-1:0] k_out;
    logic [`CTRL_IDX_W-1:0] i;
    logic [`CTRL_IDX_W-1:0] j;
    logic [`CTRL_IDX_W-1:0] k_in;
  } tile_index_t;

  // Depthwise has no k_in loop, so every index moves down one slot.
  typedef struct packed {
    logic [`CTRL_IDX_W-1:0] spare;
    logic [`CTRL_IDX_W-1:0] k_out;
    logic [`CTRL_IDX_W-1:0] i;
    logic [`CTRL_IDX_W-1:0] j;
  } loop_dw_view_t;

  typedef union packed {
    logic [`CTRL_NB_LOOPS-1:0][`CTRL_IDX_W-1:0] slot; // Slot 0 is innermost.
    tile_index_t                                normal;
    loop_dw_view_t                              dw;
  } loop_word_u;

  typedef struct packed {
    logic                      valid;
    loop_word_u                word;
    logic [`CTRL_NB_LOOPS-1:0] update;
    logic                      wrapped;
  } loop_flags_t;

  typedef struct packed {
    logic [`CTRL_ADDR_W-1:0] weights;
    logic [`CTRL_ADDR_W-1:0] infeat;
    logic [`CTRL_ADDR_W-1:0] outfeat;
  } base_addr_t;

endpackage

// File: tile_loop_counter.sv
`timescale 1ns/10ps
`include "conv_ctrl_consts.svh"

module tile_loop_counter import conv_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  ctrl_config_t config_i,
  input  logic         step_i,
  output loop_flags_t  flags_o
);

  localparam int unsigned NL = `CTRL_NB_LOOPS;
  localparam int unsigned IW = `CTRL_IDX_W;

  logic [NL-1:0][IW-1:0] range_sel;
  logic [NL-1:0][IW-1:0] idx_q;
  logic [NL-1:0][IW-1:0] idx_nxt;
  logic [NL:0]           carry;
  logic [NL-1:0]         upd;
  loop_flags_t           flags_q;

  // Ranges per slot, innermost first.
  always_comb begin
    if (config_i.filter_mode == FILTER_DEPTHWISE) begin
      range_sel[0] = config_i.nb_wo;
      range_sel[1] = config_i.nb_ho;
      range_sel[2] = config_i.nb_ko;
      range_sel[3] = IW'(1); // Outer slot never leaves zero.
    end else begin
      range_sel[0] = config_i.nb_ki;
      range_sel[1] = config_i.nb_wo;
      range_sel[2] = config_i.nb_ho;
      range_sel[3] = config_i.nb_ko;
    end
  end

  // Carry chain.
  always_comb begin
    carry[0] = 1'b1;
    for (int l = 0; l < NL; l++) begin
      if (!carry[l]) begin
        idx_nxt[l]   = idx_q[l];
        carry[l+1]   = 1'b0;
      end else if ({1'b0, idx_q[l]} + 1'b1 >= {1'b0, range_sel[l]}) begin
        idx_nxt[l]   = '0;
        carry[l+1]   = 1'b1;
      end else begin
        idx_nxt[l]   = idx_q[l] + 1'b1;
        carry[l+1]   = 1'b0;
      end
      upd[l] = (idx_nxt[l] != idx_q[l]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (clear_i || start_i) begin
      idx_q <= '0;
    end else if (step_i) begin
      idx_q <= idx_nxt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_q <= '0;
    end else begin
      flags_q.valid <= step_i & ~clear_i & ~start_i;
      if (step_i) begin
        flags_q.word.slot <= idx_nxt;
        flags_q.update    <= upd;
        flags_q.wrapped   <= carry[NL]; // Unused depthwise slot passes the carry on.
      end
    end
  end

  assign flags_o = flags_q;

endmodule

// File: tile_addr_gen.sv
`timescale 1ns/10ps
`include "conv_ctrl_consts.svh"

module tile_addr_gen import conv_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  ctrl_config_t config_i,
  input  loop_flags_t  flags_i,
  output tile_index_t  index_o,
  output base_addr_t   base_addr_o,
  output logic         tile_valid_o
);

  localparam int unsigned AW = `CTRL_ADDR_W;

  tile_index_t idx;
  base_addr_t  addr;
  tile_index_t index_q;
  base_addr_t  addr_q;
  logic        valid_q;

  always_comb begin
    if (config_i.filter_mode == FILTER_DEPTHWISE) begin
      idx.k_out = flags_i.word.dw.k_out;
      idx.i     = flags_i.word.dw.i;
      idx.j     = flags_i.word.dw.j;
      idx.k_in  = flags_i.word.dw.k_out; // k_in mirrors k_out.
    end else begin
      idx = flags_i.word.normal;
    end
  end

  assign addr.weights = AW'(idx.k_out) * AW'(config_i.w_stride_ko)
                      + AW'(idx.k_in)  * AW'(config_i.w_stride_ki);

  assign addr.infeat  = AW'(idx.i)     * AW'(config_i.x_stride_i)
                      + AW'(idx.j)     * AW'(config_i.x_stride_j)
                      + AW'(idx.k_in)  * AW'(config_i.x_stride_k);

  assign addr.outfeat = AW'(idx.i)     * AW'(config_i.y_stride_i)
                      + AW'(idx.j)     * AW'(config_i.y_stride_j)
                      + AW'(idx.k_out) * AW'(config_i.y_stride_k);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      index_q <= '0;
      addr_q  <= '0;
    end else begin
      valid_q <= flags_i.valid & ~clear_i;
      if (clear_i || start_i) begin
        index_q <= '0; // Zero index maps to zero addresses.
        addr_q  <= '0;
      end else if (flags_i.valid) begin
        index_q <= idx;
        addr_q  <= addr;
      end
    end
  end

  assign index_o      = index_q;
  assign base_addr_o  = addr_q;
  assign tile_valid_o = valid_q;

endmodule

// File: conv_sequencer.sv
`timescale 1ns/10ps

module conv_sequencer import conv_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  ctrl_config_t config_i,
  input  engine_evt_t  evt_i,
  input  loop_flags_t  flags_i,
  output logic         step_o,
  output ctrl_state_e  state_o,
  output logic         state_change_o,
  output logic         done_o
);

  ctrl_state_e state_d;
  ctrl_state_e state_q;
  logic        change_d;
  logic        change_q;
  logic        wrap_q;
  logic        k_in_only;

  // Only k_in moved, so the same output tile keeps accumulating.
  assign k_in_only = (config_i.filter_mode == FILTER_NORMAL) &&
                     (flags_i.update == 4'b0001) && !flags_i.wrapped;

  always_comb begin
    state_d = state_q;

    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = LOAD;
        end
      end

      LOAD: begin
        if (evt_i.load_done) begin
          state_d = WEIGHTOFFS;
        end
      end

      WEIGHTOFFS: begin
        if (evt_i.accum_done) begin
          state_d = MATRIXVEC;
        end
      end

      MATRIXVEC: begin
        if (evt_i.accum_done) begin
          state_d = UPDATEIDX;
        end
      end

      UPDATEIDX: begin
        if (flags_i.valid) begin
          if (k_in_only) begin
            state_d = LOAD;
          end else if (config_i.quant_en) begin
            state_d = NORMQUANT;
          end else begin
            state_d = STREAMOUT;
          end
        end
      end

      NORMQUANT: begin
        if (evt_i.nq_done) begin
          state_d = config_i.bias_en ? NORMQUANT_BIAS : STREAMOUT;
        end
      end

      NORMQUANT_BIAS: begin
        if (evt_i.nq_bias_done) begin
          state_d = STREAMOUT;
        end
      end

      STREAMOUT: begin
        if (evt_i.streamout_done) begin
          state_d = wrap_q ? DONE : LOAD; // Last tile once the walk wrapped.
        end
      end

      DONE: begin
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    change_d = (state_d != state_q);

    if (clear_i) begin
      state_d  = IDLE;
      change_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      change_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      change_q <= change_d;
    end
  end

  // Wrap result of the most recent index step.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wrap_q <= 1'b0;
    end else if (clear_i || (state_q == IDLE && start_i)) begin
      wrap_q <= 1'b0;
    end else if (state_q == UPDATEIDX && flags_i.valid) begin
      wrap_q <= flags_i.wrapped;
    end
  end

  assign step_o         = change_q && (state_q == UPDATEIDX) && !clear_i; // On entry.
  assign state_o        = state_q;
  assign state_change_o = change_q;
  assign done_o         = (state_q == DONE) && !clear_i;

endmodule

// File: conv_ctrl_top.sv
`timescale 1ns/10ps

module conv_ctrl_top import conv_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         start_i,
  input  ctrl_config_t config_i,
  input  engine_evt_t  evt_i,
  output ctrl_state_e  state_o,
  output logic         state_change_o,
  output tile_index_t  index_o,
  output base_addr_t   base_addr_o,
  output logic         tile_valid_o,
  output logic         done_o
);

  logic        step;
  loop_flags_t flags;

  tile_loop_counter i_counter (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .clear_i  ( clear_i  ),
    .start_i  ( start_i  ),
    .config_i ( config_i ),
    .step_i   ( step     ),
    .flags_o  ( flags    )
  );

  tile_addr_gen i_addr_gen (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .start_i      ( start_i      ),
    .config_i     ( config_i     ),
    .flags_i      ( flags        ),
    .index_o      ( index_o      ),
    .base_addr_o  ( base_addr_o  ),
    .tile_valid_o ( tile_valid_o )
  );

  conv_sequencer i_sequencer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .config_i       ( config_i       ),
    .evt_i          ( evt_i          ),
    .flags_i        ( flags          ),
    .step_o         ( step           ),
    .state_o        ( state_o        ),
    .state_change_o ( state_change_o ),
    .done_o         ( done_o         )
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned RST_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o; // 8 ns period.
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1; // Released away from the active edge.
  end

endmodule

// File: conv_ctrl_tb.sv
`timescale 1ns/10ps

module conv_ctrl_tb import conv_ctrl_pkg::*; ();

  logic         clk;
  logic         rst_n;
  logic         clear = 1'b0;
  logic         start = 1'b0;
  ctrl_config_t cfg = '0;
  engine_evt_t  evt = '0;
  ctrl_state_e  state;
  logic         state_change;
  tile_index_t  index;
  base_addr_t   base_addr;
  logic         tile_valid;
  logic         done;

  logic [31:0]  rng_state = 32'd27;
  int           value_errors = 0;
  int           other_errors = 0;
  int           wait_cnt = 0;
  logic         clear_q = 1'b0;
  ctrl_state_e  last_state = IDLE;
  ctrl_state_e  after_update = IDLE;
  int unsigned  ref_steps = 0;
  int unsigned  tile_cnt = 0;
  int unsigned  shortcut_cnt = 0;
  int unsigned  done_cnt = 0;
  logic         last_wrap = 1'b0;
  tile_index_t  exp_idx = '0;

  tb_clock_gen i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  conv_ctrl_top DUT (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .clear_i        ( clear        ),
    .start_i        ( start        ),
    .config_i       ( cfg          ),
    .evt_i          ( evt          ),
    .state_o        ( state        ),
    .state_change_o ( state_change ),
    .index_o        ( index        ),
    .base_addr_o    ( base_addr    ),
    .tile_valid_o   ( tile_valid   ),
    .done_o         ( done         )
  );

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int unsigned total_tiles(ctrl_config_t c);
    if (c.filter_mode == FILTER_DEPTHWISE) begin
      return 32'(c.nb_ko) * 32'(c.nb_ho) * 32'(c.nb_wo);
    end
    return 32'(c.nb_ko) * 32'(c.nb_ho) * 32'(c.nb_wo) * 32'(c.nb_ki);
  endfunction

  // Step count decoded in mixed radix with the innermost loop fastest.
  function automatic tile_index_t walk_index(ctrl_config_t c, int unsigned n);
    int unsigned rest;
    tile_index_t t;
    rest = n % total_tiles(c);
    t.k_in = '0;
    if (c.filter_mode == FILTER_NORMAL) begin
      t.k_in = 8'(rest % 32'(c.nb_ki));
      rest   = rest / 32'(c.nb_ki);
    end
    t.j     = 8'(rest % 32'(c.nb_wo));
    rest    = rest / 32'(c.nb_wo);
    t.i     = 8'(rest % 32'(c.nb_ho));
    t.k_out = 8'(rest / 32'(c.nb_ho));
    if (c.filter_mode == FILTER_DEPTHWISE) begin
      t.k_in = t.k_out;
    end
    return t;
  endfunction

  function automatic base_addr_t addr_of(ctrl_config_t c, tile_index_t t);
    base_addr_t a;
    a.weights = 32'(t.k_out) * 32'(c.w_stride_ko) + 32'(t.k_in) * 32'(c.w_stride_ki);
    a.infeat  = 32'(t.i) * 32'(c.x_stride_i) + 32'(t.j) * 32'(c.x_stride_j)
              + 32'(t.k_in) * 32'(c.x_stride_k);
    a.outfeat = 32'(t.i) * 32'(c.y_stride_i) + 32'(t.j) * 32'(c.y_stride_j)
              + 32'(t.k_out) * 32'(c.y_stride_k);
    return a;
  endfunction

  function automatic logic [15:0] nonzero_stride();
    return 16'(xorshift32() % 32'hFFFF) + 16'd1;
  endfunction

  function automatic ctrl_config_t make_config(filter_mode_e mode, int ko, int ho, int wo,
                                               int ki, logic quant, logic bias);
    ctrl_config_t c;
    c             = '0;
    c.filter_mode = mode;
    c.nb_ko       = 8'(ko);
    c.nb_ho       = 8'(ho);
    c.nb_wo       = 8'(wo);
    c.nb_ki       = 8'(ki);
    c.quant_en    = quant;
    c.bias_en     = bias;
    c.w_stride_ko = nonzero_stride();
    c.w_stride_ki = nonzero_stride();
    c.x_stride_i  = nonzero_stride();
    c.x_stride_j  = nonzero_stride();
    c.x_stride_k  = nonzero_stride();
    c.y_stride_i  = nonzero_stride();
    c.y_stride_j  = nonzero_stride();
    c.y_stride_k  = nonzero_stride();
    return c;
  endfunction

  function automatic ctrl_state_e expected_next(ctrl_state_e from);
    case (from)
      IDLE:           return LOAD;
      LOAD:           return WEIGHTOFFS;
      WEIGHTOFFS:     return MATRIXVEC;
      MATRIXVEC:      return UPDATEIDX;
      UPDATEIDX:      return after_update;
      NORMQUANT:      return cfg.bias_en ? NORMQUANT_BIAS : STREAMOUT;
      NORMQUANT_BIAS: return STREAMOUT;
      STREAMOUT:      return last_wrap ? DONE : LOAD;
      default:        return IDLE;
    endcase
  endfunction

  task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic advance_reference();
    ref_steps++;
    exp_idx   = walk_index(cfg, ref_steps);
    last_wrap = (ref_steps == total_tiles(cfg));
    // k_in alone moves unless it rolls over.
    if (cfg.filter_mode == FILTER_NORMAL && ref_steps % 32'(cfg.nb_ki) != 0) begin
      after_update = LOAD;
    end else if (cfg.quant_en) begin
      after_update = NORMQUANT;
    end else begin
      after_update = STREAMOUT;
    end
  endtask

  // Engine model answers each waiting state after 1 to 6 cycles.
  always @(negedge clk) begin
    evt = '0;
    if (state_change && state inside {LOAD, WEIGHTOFFS, MATRIXVEC, NORMQUANT,
                                      NORMQUANT_BIAS, STREAMOUT}) begin
      wait_cnt = 1 + int'(xorshift32() % 6);
    end
    if (wait_cnt > 0) begin
      wait_cnt--;
      if (wait_cnt == 0) begin
        case (state)
          LOAD:                  evt.load_done      = 1'b1;
          WEIGHTOFFS, MATRIXVEC: evt.accum_done     = 1'b1;
          NORMQUANT:             evt.nq_done        = 1'b1;
          NORMQUANT_BIAS:        evt.nq_bias_done   = 1'b1;
          STREAMOUT:             evt.streamout_done = 1'b1;
          default:               evt                = '0;
        endcase
      end
    end
  end

  always @(posedge clk) begin
    clear_q <= clear;
  end

  // Output monitor sampled mid-cycle.
  always @(negedge clk) begin
    logic pulse_expected;
    if (rst_n) begin
      if (!clear_q) begin
        check_value("state_change_o", state != last_state, state_change);
      end
      if (state_change) begin
        check_value("state_o", expected_next(last_state), state);
        if (last_state == UPDATEIDX && state == LOAD) begin
          shortcut_cnt++;
        end
        if (state == UPDATEIDX) begin
          advance_reference();
        end
      end
      pulse_expected = state_change && (last_state == UPDATEIDX);
      assert (tile_valid == pulse_expected) else begin
        other_errors++;
        $display("tile_valid_o pulse missing or unexpected at %0t", $time);
      end
      if (tile_valid) begin
        tile_cnt++;
        check_value("index_o", exp_idx, index);
        check_value("base_addr_o", addr_of(cfg, exp_idx), base_addr);
        if (cfg.filter_mode == FILTER_DEPTHWISE) begin
          check_value("index_o.k_in", exp_idx.k_out, index.k_in);
        end
      end
      check_value("done_o", state == DONE, done);
      if (done) begin
        done_cnt++;
      end
    end
    last_state = state;
  end

  updateidx_two_cycles: assert property (@(posedge clk) disable iff (!rst_n || clear)
    (state == UPDATEIDX && state_change) |=>
      (state == UPDATEIDX && !state_change) ##1 (state != UPDATEIDX))
  else begin
    other_errors++;
    $display("UPDATEIDX did not last exactly two cycles at %0t", $time);
  end

  done_then_idle: assert property (@(posedge clk) disable iff (!rst_n || clear)
    done |=> (!done && state == IDLE))
  else begin
    other_errors++;
    $display("State did not return to IDLE right after done_o at %0t", $time);
  end

  tile_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
    tile_valid |=> !tile_valid)
  else begin
    other_errors++;
    $display("tile_valid_o stayed high for more than one cycle at %0t", $time);
  end

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      other_errors++;
      $display("Reset was never released");
    end
  endtask

  task automatic wait_for_tiles(int unsigned n);
    int cycles;
    cycles = 0;
    while (tile_cnt < n && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (tile_cnt < n) begin
      other_errors++;
      $display("Timeout waiting for %0d tiles at %0t", n, $time);
    end
  endtask

  task automatic start_job(ctrl_config_t c);
    @(negedge clk);
    cfg          = c;
    ref_steps    = 0;
    tile_cnt     = 0;
    shortcut_cnt = 0;
    done_cnt     = 0;
    last_wrap    = 1'b0;
    start        = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic finish_job();
    int cycles;
    int unsigned total;
    int unsigned shortcuts;
    cycles = 0;
    while ((done_cnt == 0 || state != IDLE) && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    if (done_cnt == 0 || state != IDLE) begin
      other_errors++;
      $display("Timeout: job did not finish and return to IDLE at %0t", $time);
    end
    repeat (3) @(negedge clk); // Catches a second done_o pulse.
    total     = total_tiles(cfg);
    shortcuts = (cfg.filter_mode == FILTER_NORMAL) ? total - total / 32'(cfg.nb_ki) : 0;
    check_value("tile_valid_o pulse count", total, tile_cnt);
    check_value("done_o pulse count", 1, done_cnt);
    check_value("LOAD shortcut count", shortcuts, shortcut_cnt);
  endtask

  initial begin
    ctrl_config_t c;
    wait_for_reset();
    @(negedge clk);
    check_value("state_o", IDLE, state);
    check_value("state_change_o", 0, state_change);
    check_value("tile_valid_o", 0, tile_valid);
    check_value("done_o", 0, done);
    check_value("index_o", 0, index);
    check_value("base_addr_o", 0, base_addr);

    // Normal mode with all loops of two and quantization with bias.
    c = make_config(FILTER_NORMAL, 2, 2, 2, 2, 1'b1, 1'b1);
    start_job(c);
    finish_job();

    c = make_config(FILTER_DEPTHWISE, 3, 2, 2, 0, 1'b1, 1'b0);
    start_job(c);
    finish_job();

    c = make_config(FILTER_NORMAL, 1, 2, 1, 3, 1'b0, 1'b1); // Straight to STREAMOUT.
    start_job(c);
    finish_job();

    // Abort mid-job and rerun the same configuration.
    c = make_config(FILTER_NORMAL, 2, 2, 2, 2, 1'b1, 1'b1);
    start_job(c);
    wait_for_tiles(3);
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    check_value("state_o", IDLE, state);
    check_value("index_o", 0, index);
    start_job(c);
    finish_job();

    $display("Error counts: value checks %0d, other failures %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
conv_ctrl_pkg.sv
tile_loop_counter.sv
tile_addr_gen.sv
conv_sequencer.sv
conv_ctrl_top.sv
tb_clock_gen.sv
conv_ctrl_tb.sv
